// ==== verilog/udma_lite_consts.svh ====
// ==============================
// widths, register word addresses and
// channel CFG bit positions
// ==============================

`ifndef UDMA_LITE_CONSTS_SVH
`define UDMA_LITE_CONSTS_SVH

// L2 byte address and transfer size
`define UDMA_L2_AWIDTH    21
`define UDMA_TRANS_SIZE   20

`define UDMA_DATA_WIDTH   32

// config bus word address
`define UDMA_CFG_AWIDTH   5

// bits inside RX_CFG / TX_CFG
`define UDMA_CFG_CONT_BIT 0
`define UDMA_CFG_EN_BIT   4
`define UDMA_CFG_CLR_BIT  5

`endif

// ==== verilog/udma_lite_pkg.sv ====
// ==============================
// shared types of the uDMA lite
// ==============================

`include "udma_lite_consts.svh"

package udma_lite_pkg;

    typedef logic [`UDMA_L2_AWIDTH-1:0]  l2_addr_t;     // byte address
    typedef logic [`UDMA_TRANS_SIZE-1:0] trans_size_t;  // byte count
    typedef logic [`UDMA_DATA_WIDTH-1:0] word_t;

    // register word addresses, 3 and 7 are holes
    typedef enum logic [`UDMA_CFG_AWIDTH-1:0] {
        REG_RX_SADDR = 5'd0,
        REG_RX_SIZE  = 5'd1,
        REG_RX_CFG   = 5'd2,
        REG_TX_SADDR = 5'd4,
        REG_TX_SIZE  = 5'd5,
        REG_TX_CFG   = 5'd6
    } reg_addr_e;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_REQ,   // L2 request out
        CH_WAIT,  // read granted, data not back yet
        CH_HOLD   // word held for the stream
    } ch_state_e;

endpackage

// ==== verilog/udma_ch_if.sv ====
// ==============================
// config and status of one channel
// ==============================

interface udma_ch_if;
    import udma_lite_pkg::*;

    l2_addr_t    cfg_startaddr;
    trans_size_t cfg_size;
    logic        cfg_continuous;
    logic        cfg_en;          // one-cycle start pulse
    logic        cfg_clr;         // one-cycle abort pulse

    logic        ch_en;           // transfer active
    l2_addr_t    curr_addr;
    trans_size_t bytes_left;
    logic        eot;

    modport regs (
        output cfg_startaddr, cfg_size, cfg_continuous, cfg_en, cfg_clr,
        input  ch_en, curr_addr, bytes_left, eot
    );

    modport ch (
        input  cfg_startaddr, cfg_size, cfg_continuous, cfg_en, cfg_clr,
        output ch_en, curr_addr, bytes_left, eot
    );

endinterface

// ==== verilog/udma_tx_ch.sv ====
// ==============================
// transmit linear channel
// L2 read port to outgoing stream
// ==============================

module udma_tx_ch (
    input  logic                     sys_clk_i,
    input  logic                     reset_i,

    udma_ch_if.ch                    ch,

    output logic                     l2_req_o,
    input  logic                     l2_gnt_i,
    output udma_lite_pkg::l2_addr_t  l2_addr_o,
    input  logic                     l2_rvalid_i,
    input  udma_lite_pkg::word_t     l2_rdata_i,

    output udma_lite_pkg::word_t     tx_data_o,
    output logic                     tx_valid_o,
    input  logic                     tx_ready_i
);
    import udma_lite_pkg::*;

    ch_state_e   state_q;
    l2_addr_t    addr_q;
    trans_size_t left_q;
    trans_size_t left_step;
    word_t       data_q;
    logic        eot_q;

    // saturate so an odd size still ends the transfer
    assign left_step = (left_q > trans_size_t'(4)) ? left_q - trans_size_t'(4) : '0;

    always_ff @(posedge sys_clk_i)
    begin
        if (reset_i)
        begin
            state_q <= CH_IDLE;
            addr_q  <= '0;
            left_q  <= '0;
            eot_q   <= 1'b0;
        end
        else
        begin
            eot_q <= 1'b0;
            if (ch.cfg_clr)
                state_q <= CH_IDLE;  // a read in flight is dropped
            else
            begin
                case (state_q)
                    CH_IDLE:
                        if (ch.cfg_en)
                        begin
                            addr_q  <= ch.cfg_startaddr;
                            left_q  <= ch.cfg_size;
                            state_q <= CH_REQ;
                        end
                    CH_REQ:
                        if (l2_gnt_i)
                        begin
                            addr_q  <= addr_q + l2_addr_t'(4);
                            left_q  <= left_step;
                            state_q <= CH_WAIT;
                        end
                    CH_WAIT:
                        if (l2_rvalid_i)
                            state_q <= CH_HOLD;
                    CH_HOLD:
                        if (tx_ready_i)
                        begin
                            if (left_q != '0)
                                state_q <= CH_REQ;
                            else
                            begin
                                eot_q <= 1'b1;
                                if (ch.cfg_continuous)
                                begin
                                    addr_q  <= ch.cfg_startaddr;  // next pass
                                    left_q  <= ch.cfg_size;
                                    state_q <= CH_REQ;
                                end
                                else
                                    state_q <= CH_IDLE;
                            end
                        end
                    default:
                        state_q <= CH_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (state_q == CH_WAIT && l2_rvalid_i)
            data_q <= l2_rdata_i;
    end

    assign l2_req_o   = (state_q == CH_REQ);
    assign l2_addr_o  = addr_q;
    assign tx_valid_o = (state_q == CH_HOLD);
    assign tx_data_o  = data_q;

    assign ch.ch_en      = (state_q != CH_IDLE);
    assign ch.curr_addr  = addr_q;
    assign ch.bytes_left = left_q;
    assign ch.eot        = eot_q;

endmodule

// ==== verilog/udma_rx_ch.sv ====
// ==============================
// receive linear channel
// incoming stream to L2 write port
// ==============================

module udma_rx_ch (
    input  logic                     sys_clk_i,
    input  logic                     reset_i,

    udma_ch_if.ch                    ch,

    input  udma_lite_pkg::word_t     rx_data_i,
    input  logic                     rx_valid_i,
    output logic                     rx_ready_o,

    output logic                     l2_req_o,
    input  logic                     l2_gnt_i,
    output udma_lite_pkg::l2_addr_t  l2_addr_o,
    output udma_lite_pkg::word_t     l2_wdata_o,
    output logic [3:0]               l2_be_o
);
    import udma_lite_pkg::*;

    ch_state_e   state_q;
    l2_addr_t    addr_q;
    trans_size_t left_q;
    trans_size_t left_step;
    word_t       data_q;
    logic        eot_q;

    assign left_step = (left_q > trans_size_t'(4)) ? left_q - trans_size_t'(4) : '0;

    // CH_HOLD waits for a stream word, CH_REQ holds the L2 write
    always_ff @(posedge sys_clk_i)
    begin
        if (reset_i)
        begin
            state_q <= CH_IDLE;
            addr_q  <= '0;
            left_q  <= '0;
            eot_q   <= 1'b0;
        end
        else
        begin
            eot_q <= 1'b0;
            if (ch.cfg_clr)
                state_q <= CH_IDLE;
            else
            begin
                case (state_q)
                    CH_IDLE:
                        if (ch.cfg_en)
                        begin
                            addr_q  <= ch.cfg_startaddr;
                            left_q  <= ch.cfg_size;
                            state_q <= CH_HOLD;
                        end
                    CH_HOLD:
                        if (rx_valid_i)
                            state_q <= CH_REQ;
                    CH_REQ:
                        if (l2_gnt_i)
                        begin
                            addr_q <= addr_q + l2_addr_t'(4);
                            left_q <= left_step;
                            if (left_step != '0)
                                state_q <= CH_HOLD;
                            else
                            begin
                                eot_q <= 1'b1;  // last word written
                                if (ch.cfg_continuous)
                                begin
                                    addr_q  <= ch.cfg_startaddr;
                                    left_q  <= ch.cfg_size;
                                    state_q <= CH_HOLD;
                                end
                                else
                                    state_q <= CH_IDLE;
                            end
                        end
                    default:
                        state_q <= CH_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (rx_ready_o && rx_valid_i)
            data_q <= rx_data_i;
    end

    assign rx_ready_o = (state_q == CH_HOLD);
    assign l2_req_o   = (state_q == CH_REQ);
    assign l2_addr_o  = addr_q;
    assign l2_wdata_o = data_q;
    assign l2_be_o    = 4'hf;  // word writes only

    assign ch.ch_en      = (state_q != CH_IDLE);
    assign ch.curr_addr  = addr_q;
    assign ch.bytes_left = left_q;
    assign ch.eot        = eot_q;

endmodule

// ==== verilog/udma_regs.sv ====
// ==============================
// channel config registers,
// status readback and eot events
// ==============================

`include "udma_lite_consts.svh"

module udma_regs (
    input  logic                        sys_clk_i,
    input  logic                        reset_i,

    input  logic                        cfg_valid_i,
    input  logic                        cfg_rwn_i,
    input  logic [`UDMA_CFG_AWIDTH-1:0] cfg_addr_i,
    input  udma_lite_pkg::word_t        cfg_data_i,
    output udma_lite_pkg::word_t        cfg_data_o,
    output logic                        cfg_ready_o,

    udma_ch_if.regs                     rx,
    udma_ch_if.regs                     tx,

    output logic [1:0]                  events_o
);
    import udma_lite_pkg::*;

    reg_addr_e   reg_addr;
    logic        ready_q;
    logic        wr_stb;

    l2_addr_t    rx_saddr_q;
    l2_addr_t    tx_saddr_q;
    trans_size_t rx_size_q;
    trans_size_t tx_size_q;
    logic        rx_cont_q;
    logic        tx_cont_q;

    // set by a write, cleared by the start, so a written value reads back
    logic        rx_saddr_wr_q;
    logic        rx_size_wr_q;
    logic        tx_saddr_wr_q;
    logic        tx_size_wr_q;

    function automatic word_t cfg_word(input logic cont, input logic en);
        word_t w;
        w = '0;
        w[`UDMA_CFG_CONT_BIT] = cont;
        w[`UDMA_CFG_EN_BIT]   = en;
        return w;
    endfunction

    assign reg_addr    = reg_addr_e'(cfg_addr_i);
    assign wr_stb      = cfg_valid_i && !cfg_rwn_i && !ready_q;  // first cycle only
    assign cfg_ready_o = ready_q;

    always_ff @(posedge sys_clk_i)
    begin
        if (reset_i)
        begin
            ready_q       <= 1'b0;
            rx_saddr_q    <= '0;
            tx_saddr_q    <= '0;
            rx_size_q     <= '0;
            tx_size_q     <= '0;
            rx_cont_q     <= 1'b0;
            tx_cont_q     <= 1'b0;
            rx_saddr_wr_q <= 1'b0;
            rx_size_wr_q  <= 1'b0;
            tx_saddr_wr_q <= 1'b0;
            tx_size_wr_q  <= 1'b0;
            events_o      <= 2'b00;
        end
        else
        begin
            ready_q  <= cfg_valid_i && !ready_q;
            events_o <= {tx.eot, rx.eot};
            if (rx.cfg_en)
            begin
                rx_saddr_wr_q <= 1'b0;
                rx_size_wr_q  <= 1'b0;
            end
            if (tx.cfg_en)
            begin
                tx_saddr_wr_q <= 1'b0;
                tx_size_wr_q  <= 1'b0;
            end
            if (wr_stb)
            begin
                case (reg_addr)
                    REG_RX_SADDR:
                    begin
                        rx_saddr_q    <= cfg_data_i[`UDMA_L2_AWIDTH-1:0];
                        rx_saddr_wr_q <= 1'b1;
                    end
                    REG_RX_SIZE:
                    begin
                        rx_size_q    <= cfg_data_i[`UDMA_TRANS_SIZE-1:0];
                        rx_size_wr_q <= 1'b1;
                    end
                    REG_RX_CFG:
                        rx_cont_q <= cfg_data_i[`UDMA_CFG_CONT_BIT];
                    REG_TX_SADDR:
                    begin
                        tx_saddr_q    <= cfg_data_i[`UDMA_L2_AWIDTH-1:0];
                        tx_saddr_wr_q <= 1'b1;
                    end
                    REG_TX_SIZE:
                    begin
                        tx_size_q    <= cfg_data_i[`UDMA_TRANS_SIZE-1:0];
                        tx_size_wr_q <= 1'b1;
                    end
                    REG_TX_CFG:
                        tx_cont_q <= cfg_data_i[`UDMA_CFG_CONT_BIT];
                    default:
                        ;
                endcase
            end
        end
    end

    // start and abort act in the access cycle itself
    assign rx.cfg_en  = wr_stb && reg_addr == REG_RX_CFG && cfg_data_i[`UDMA_CFG_EN_BIT];
    assign rx.cfg_clr = wr_stb && reg_addr == REG_RX_CFG && cfg_data_i[`UDMA_CFG_CLR_BIT];
    assign tx.cfg_en  = wr_stb && reg_addr == REG_TX_CFG && cfg_data_i[`UDMA_CFG_EN_BIT];
    assign tx.cfg_clr = wr_stb && reg_addr == REG_TX_CFG && cfg_data_i[`UDMA_CFG_CLR_BIT];

    assign rx.cfg_startaddr  = rx_saddr_q;
    assign rx.cfg_size       = rx_size_q;
    assign rx.cfg_continuous = rx_cont_q;
    assign tx.cfg_startaddr  = tx_saddr_q;
    assign tx.cfg_size       = tx_size_q;
    assign tx.cfg_continuous = tx_cont_q;

    always_comb
    begin
        case (reg_addr)
            REG_RX_SADDR: cfg_data_o = word_t'(rx_saddr_wr_q ? rx_saddr_q : rx.curr_addr);
            REG_RX_SIZE:  cfg_data_o = word_t'(rx_size_wr_q ? rx_size_q : rx.bytes_left);
            REG_RX_CFG:   cfg_data_o = cfg_word(rx_cont_q, rx.ch_en);
            REG_TX_SADDR: cfg_data_o = word_t'(tx_saddr_wr_q ? tx_saddr_q : tx.curr_addr);
            REG_TX_SIZE:  cfg_data_o = word_t'(tx_size_wr_q ? tx_size_q : tx.bytes_left);
            REG_TX_CFG:   cfg_data_o = cfg_word(tx_cont_q, tx.ch_en);
            default:      cfg_data_o = '0;  // unmapped
        endcase
    end

endmodule

// ==== verilog/udma_lite.sv ====
// ==============================
// uDMA lite top level
// ==============================

`include "udma_lite_consts.svh"

module udma_lite (
    input  logic                        sys_clk_i,
    input  logic                        reset_i,

    input  logic                        cfg_valid_i,
    input  logic                        cfg_rwn_i,
    input  logic [`UDMA_CFG_AWIDTH-1:0] cfg_addr_i,
    input  udma_lite_pkg::word_t        cfg_data_i,
    output udma_lite_pkg::word_t        cfg_data_o,
    output logic                        cfg_ready_o,

    output logic                        l2_ro_wen_o,
    output logic                        l2_ro_req_o,
    input  logic                        l2_ro_gnt_i,
    output logic [31:0]                 l2_ro_addr_o,
    input  logic                        l2_ro_rvalid_i,
    input  udma_lite_pkg::word_t        l2_ro_rdata_i,

    output logic                        l2_wo_wen_o,
    output logic                        l2_wo_req_o,
    input  logic                        l2_wo_gnt_i,
    output logic [31:0]                 l2_wo_addr_o,
    output udma_lite_pkg::word_t        l2_wo_wdata_o,
    output logic [3:0]                  l2_wo_be_o,

    output udma_lite_pkg::word_t        tx_data_o,
    output logic                        tx_valid_o,
    input  logic                        tx_ready_i,

    input  udma_lite_pkg::word_t        rx_data_i,
    input  logic                        rx_valid_i,
    output logic                        rx_ready_o,

    output logic [1:0]                  events_o
);
    import udma_lite_pkg::*;

    l2_addr_t tx_l2_addr;
    l2_addr_t rx_l2_addr;

    udma_ch_if rx_if ();
    udma_ch_if tx_if ();

    assign l2_ro_wen_o  = 1'b1;  // wen is active low
    assign l2_wo_wen_o  = 1'b0;
    assign l2_ro_addr_o = 32'(tx_l2_addr);
    assign l2_wo_addr_o = 32'(rx_l2_addr);

    udma_regs udma_regs_i (
        .sys_clk_i   ( sys_clk_i   ),
        .reset_i     ( reset_i     ),
        .cfg_valid_i ( cfg_valid_i ),
        .cfg_rwn_i   ( cfg_rwn_i   ),
        .cfg_addr_i  ( cfg_addr_i  ),
        .cfg_data_i  ( cfg_data_i  ),
        .cfg_data_o  ( cfg_data_o  ),
        .cfg_ready_o ( cfg_ready_o ),
        .rx          ( rx_if       ),
        .tx          ( tx_if       ),
        .events_o    ( events_o    )
    );

    udma_tx_ch udma_tx_ch_i (
        .sys_clk_i   ( sys_clk_i      ),
        .reset_i     ( reset_i        ),
        .ch          ( tx_if          ),
        .l2_req_o    ( l2_ro_req_o    ),
        .l2_gnt_i    ( l2_ro_gnt_i    ),
        .l2_addr_o   ( tx_l2_addr     ),
        .l2_rvalid_i ( l2_ro_rvalid_i ),
        .l2_rdata_i  ( l2_ro_rdata_i  ),
        .tx_data_o   ( tx_data_o      ),
        .tx_valid_o  ( tx_valid_o     ),
        .tx_ready_i  ( tx_ready_i     )
    );

    udma_rx_ch udma_rx_ch_i (
        .sys_clk_i   ( sys_clk_i     ),
        .reset_i     ( reset_i       ),
        .ch          ( rx_if         ),
        .rx_data_i   ( rx_data_i     ),
        .rx_valid_i  ( rx_valid_i    ),
        .rx_ready_o  ( rx_ready_o    ),
        .l2_req_o    ( l2_wo_req_o   ),
        .l2_gnt_i    ( l2_wo_gnt_i   ),
        .l2_addr_o   ( rx_l2_addr    ),
        .l2_wdata_o  ( l2_wo_wdata_o ),
        .l2_be_o     ( l2_wo_be_o    )
    );

endmodule

// ==== sim/tb_l2_mem.sv ====
// ==============================
// behavioral L2 memory model
// read port and write port
// ==============================

module tb_l2_mem #(
    parameter int WORDS = 1024
) (
    input  logic        clk_i,

    input  logic        ro_req_i,
    output logic        ro_gnt_o,
    input  logic [31:0] ro_addr_i,
    output logic        ro_rvalid_o,
    output logic [31:0] ro_rdata_o,

    input  logic        wo_req_i,
    output logic        wo_gnt_o,
    input  logic [31:0] wo_addr_i,
    input  logic [31:0] wo_wdata_i,
    input  logic [3:0]  wo_be_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int AW = $clog2(WORDS);

    logic [31:0] mem [WORDS];   // loaded by the testbench
    integer      seed = 32'h98b6a0d4;
    int          rd_wait;
    int          wr_wait;
    logic [31:0] rd_addr_q;
    logic [31:0] wr_addr_q;
    logic [31:0] wr_data_q;
    logic [3:0]  wr_be_q;

    // read port, grant after 0 to 2 cycles, rvalid one cycle after the grant
    initial
    begin
        ro_gnt_o    = 1'b0;
        ro_rvalid_o = 1'b0;
        ro_rdata_o  = '0;
        rd_wait     = -1;
        forever
        begin
            @(posedge clk_i);
            #1;
            ro_rvalid_o = 1'b0;
            if (ro_gnt_o)
            begin
                ro_gnt_o    = 1'b0;   // grant taken at this edge
                ro_rvalid_o = 1'b1;
                ro_rdata_o  = mem[rd_addr_q[AW+1:2]];
            end
            else if (ro_req_i)
            begin
                if (rd_wait < 0)
                    rd_wait = $unsigned($random(seed)) % 3;
                if (rd_wait == 0)
                begin
                    ro_gnt_o  = 1'b1;
                    rd_addr_q = ro_addr_i;
                end
                rd_wait = rd_wait - 1;
            end
        end
    end

    // write port, the word lands in memory at the grant edge
    initial
    begin
        wo_gnt_o = 1'b0;
        wr_wait  = -1;
        forever
        begin
            @(posedge clk_i);
            #1;
            if (wo_gnt_o)
            begin
                wo_gnt_o = 1'b0;
                for (int b = 0; b < 4; b++)
                begin
                    if (wr_be_q[b])
                        mem[wr_addr_q[AW+1:2]][8*b +: 8] = wr_data_q[8*b +: 8];
                end
            end
            else if (wo_req_i)
            begin
                if (wr_wait < 0)
                    wr_wait = $unsigned($random(seed)) % 3;
                if (wr_wait == 0)
                begin
                    wo_gnt_o  = 1'b1;
                    wr_addr_q = wo_addr_i;
                    wr_data_q = wo_wdata_i;
                    wr_be_q   = wo_be_i;
                end
                wr_wait = wr_wait - 1;
            end
        end
    end

endmodule

// ==== sim/tb_udma_lite.sv ====
// ==============================
// testbench for the uDMA lite
// stimulus, checks, watchdog, report
// ==============================

`include "udma_lite_consts.svh"

module tb_udma_lite;
    timeunit 1ns;
    timeprecision 100ps;

    import udma_lite_pkg::*;

    localparam logic [31:0] SEED = 32'h98b6a0d4;
    localparam int MEM_WORDS   = 1024;
    localparam int N_TX        = 12;
    localparam int N_RX        = 10;
    localparam int N_CONT      = 6;
    localparam int TX_BASE     = 'h40;
    localparam int RX_BASE     = 'h200;
    localparam int CONT_BASE   = 'h80;
    localparam int TOTAL_WORDS = N_TX + N_RX + 3 * N_CONT;
    localparam int WATCHDOG    = TOTAL_WORDS * 40 + 2000;
    localparam int EVT_TIMEOUT = 1000;

    localparam word_t EN_VAL   = word_t'(1) << `UDMA_CFG_EN_BIT;
    localparam word_t CONT_VAL = word_t'(1) << `UDMA_CFG_CONT_BIT;
    localparam word_t CLR_VAL  = word_t'(1) << `UDMA_CFG_CLR_BIT;

    logic        sys_clk;
    logic        reset;
    logic        cfg_valid;
    logic        cfg_rwn;
    logic [4:0]  cfg_addr;
    word_t       cfg_wdata;
    word_t       cfg_rdata;
    logic        cfg_ready;
    logic        ro_wen;
    logic        l2_ro_req;
    logic        l2_ro_gnt;
    logic [31:0] l2_ro_addr;
    logic        l2_ro_rvalid;
    word_t       l2_ro_rdata;
    logic        wo_wen;
    logic        l2_wo_req;
    logic        l2_wo_gnt;
    logic [31:0] l2_wo_addr;
    word_t       l2_wo_wdata;
    logic [3:0]  l2_wo_be;
    word_t       tx_data;
    logic        tx_valid;
    logic        tx_ready;
    word_t       rx_data;
    logic        rx_valid;
    logic        rx_ready;
    logic [1:0]  events;

    int          err_cnt;
    int          test_err_base;
    int          tests_run;
    int          tests_failed;
    int          evt_cnt [2];
    int          wr_cnt;
    logic        quiet_chk;      // no L2 request allowed while set
    word_t       tx_q [$];
    word_t       rx_words [$];
    integer      bp_seed   = SEED;
    integer      data_seed = SEED;

    udma_lite udma_lite_i (
        .sys_clk_i      ( sys_clk      ),
        .reset_i        ( reset        ),
        .cfg_valid_i    ( cfg_valid    ),
        .cfg_rwn_i      ( cfg_rwn      ),
        .cfg_addr_i     ( cfg_addr     ),
        .cfg_data_i     ( cfg_wdata    ),
        .cfg_data_o     ( cfg_rdata    ),
        .cfg_ready_o    ( cfg_ready    ),
        .l2_ro_wen_o    ( ro_wen       ),
        .l2_ro_req_o    ( l2_ro_req    ),
        .l2_ro_gnt_i    ( l2_ro_gnt    ),
        .l2_ro_addr_o   ( l2_ro_addr   ),
        .l2_ro_rvalid_i ( l2_ro_rvalid ),
        .l2_ro_rdata_i  ( l2_ro_rdata  ),
        .l2_wo_wen_o    ( wo_wen       ),
        .l2_wo_req_o    ( l2_wo_req    ),
        .l2_wo_gnt_i    ( l2_wo_gnt    ),
        .l2_wo_addr_o   ( l2_wo_addr   ),
        .l2_wo_wdata_o  ( l2_wo_wdata  ),
        .l2_wo_be_o     ( l2_wo_be     ),
        .tx_data_o      ( tx_data      ),
        .tx_valid_o     ( tx_valid     ),
        .tx_ready_i     ( tx_ready     ),
        .rx_data_i      ( rx_data      ),
        .rx_valid_i     ( rx_valid     ),
        .rx_ready_o     ( rx_ready     ),
        .events_o       ( events       )
    );

    tb_l2_mem #(.WORDS(MEM_WORDS)) l2_mem_i (
        .clk_i       ( sys_clk      ),
        .ro_req_i    ( l2_ro_req    ),
        .ro_gnt_o    ( l2_ro_gnt    ),
        .ro_addr_i   ( l2_ro_addr   ),
        .ro_rvalid_o ( l2_ro_rvalid ),
        .ro_rdata_o  ( l2_ro_rdata  ),
        .wo_req_i    ( l2_wo_req    ),
        .wo_gnt_o    ( l2_wo_gnt    ),
        .wo_addr_i   ( l2_wo_addr   ),
        .wo_wdata_i  ( l2_wo_wdata  ),
        .wo_be_i     ( l2_wo_be     )
    );

    initial
    begin
        sys_clk = 1'b0;
        forever
            #5 sys_clk = ~sys_clk;
    end

    // random back-pressure on the transmit stream
    initial
    begin
        tx_ready = 1'b0;
        forever
        begin
            @(posedge sys_clk);
            #1;
            tx_ready = ($random(bp_seed) & 3) != 0;
        end
    end

    initial
    begin
        repeat (WATCHDOG) @(posedge sys_clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
        $display("=== FAIL ===");
        $finish;
    end

    // monitors sample in the middle of the cycle
    always @(negedge sys_clk)
    begin
        if (events[0])
            evt_cnt[0]++;
        if (events[1])
            evt_cnt[1]++;
        if (tx_valid && tx_ready)
            tx_q.push_back(tx_data);
        if (l2_ro_req && l2_ro_gnt)
            check_cond(l2_ro_addr[1:0] == 2'b00 && l2_ro_addr < MEM_WORDS * 4,
                       $sformatf("L2 read address 0x%08h outside the memory", l2_ro_addr));
        if (l2_wo_req && l2_wo_gnt)
        begin
            wr_cnt++;
            check_cond(l2_wo_be == 4'hf, $sformatf("L2 write with byte enables %b", l2_wo_be));
            check_cond(l2_wo_addr[1:0] == 2'b00 && l2_wo_addr < MEM_WORDS * 4,
                       $sformatf("L2 write address 0x%08h outside the memory", l2_wo_addr));
        end
        if (quiet_chk)
            check_cond(!l2_ro_req && !l2_wo_req, "L2 request after the channel was cleared");
    end

    function automatic word_t fill_word(input int idx);
        return {idx[15:0] ^ 16'h5a3c, ~idx[15:0]};
    endfunction

    task automatic check_cond(input logic ok, input string msg);
        assert (ok)
        else
        begin
            err_cnt++;
            $display("ERR @%0t: %s", $time, msg);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge sys_clk);
        #1;
    endtask

    // host side of the config bus, ready must come exactly one cycle after valid
    task automatic cfg_access(input logic rwn, input logic [4:0] addr, input word_t wdata,
                              output word_t rdata);
        cfg_valid = 1'b1;
        cfg_rwn   = rwn;
        cfg_addr  = addr;
        cfg_wdata = rwn ? '0 : wdata;
        @(negedge sys_clk);
        check_cond(!cfg_ready, "cfg_ready high in the cycle valid rose");
        @(negedge sys_clk);
        check_cond(cfg_ready, "cfg_ready missing one cycle after valid");
        rdata = cfg_rdata;
        @(posedge sys_clk);
        #1;
        cfg_valid = 1'b0;
        @(negedge sys_clk);
        check_cond(!cfg_ready, "cfg_ready high for more than one cycle");
        @(posedge sys_clk);
        #1;
    endtask

    task automatic cfg_write(input logic [4:0] addr, input word_t data);
        word_t unused;
        cfg_access(1'b0, addr, data, unused);
    endtask

    task automatic check_reg(input logic [4:0] addr, input word_t mask, input word_t exp,
                             input string what);
        word_t got;
        cfg_access(1'b1, addr, '0, got);
        check_cond((got & mask) == exp,
                   $sformatf("%s read 0x%08h, expected 0x%08h", what, got & mask, exp));
    endtask

    task automatic wait_events(input int idx, input int target, input string what);
        int n;
        n = 0;
        while (evt_cnt[idx] < target && n < EVT_TIMEOUT)
        begin
            @(posedge sys_clk);
            #1;
            n++;
        end
        if (evt_cnt[idx] < target)
        begin
            err_cnt++;
            $display("timeout: no %s within %0d cycles", what, EVT_TIMEOUT);
        end
    endtask

    task automatic send_rx_word(input word_t w);
        logic acc;
        acc      = 1'b0;
        rx_valid = 1'b1;
        rx_data  = w;
        while (!acc)
        begin
            @(negedge sys_clk);
            acc = rx_ready;
            @(posedge sys_clk);
            #1;
        end
        rx_valid = 1'b0;
    endtask

    // stream words must follow the buffer, wrapping per pass
    task automatic check_tx_words(input int first, input int n, input int min_len,
                                  input int max_len);
        check_cond(tx_q.size() >= min_len && tx_q.size() <= max_len,
                   $sformatf("%0d stream words, expected %0d to %0d", tx_q.size(), min_len,
                             max_len));
        foreach (tx_q[i])
            check_cond(tx_q[i] == fill_word(first + i % n),
                       $sformatf("stream word %0d is 0x%08h, expected 0x%08h", i, tx_q[i],
                                 fill_word(first + i % n)));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == test_err_base)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    task automatic run_reset_test();
        @(negedge sys_clk);
        check_cond(!l2_ro_req && !l2_wo_req, "L2 request active after reset");
        check_cond(!tx_valid && !rx_ready, "stream handshake active after reset");
        check_cond(!cfg_ready && events == 2'b00, "cfg_ready or event high after reset");
        check_cond(ro_wen && !wo_wen, "fixed L2 write enables wrong");
        idle_cycles(1);
        end_test("reset state");
    endtask

    task automatic run_regs_test();
        cfg_write(REG_TX_SADDR, 32'h0001_2340);
        cfg_write(REG_TX_SIZE, 32'h0000_0abc);
        cfg_write(REG_RX_SADDR, 32'h001f_fffc);
        cfg_write(REG_RX_SIZE, 32'h000f_fff0);
        check_reg(REG_TX_SADDR, '1, 32'h0001_2340, "TX_SADDR");
        check_reg(REG_TX_SIZE, '1, 32'h0000_0abc, "TX_SIZE");
        check_reg(REG_RX_SADDR, '1, 32'h001f_fffc, "RX_SADDR");
        check_reg(REG_RX_SIZE, '1, 32'h000f_fff0, "RX_SIZE");
        check_reg(5'd3, '1, '0, "unmapped word 3");
        check_reg(5'd7, '1, '0, "unmapped word 7");
        check_reg(5'd31, '1, '0, "unmapped word 31");
        end_test("register readback");
    endtask

    task automatic run_tx_test();
        int base;
        base = evt_cnt[1];
        tx_q.delete();
        cfg_write(REG_TX_SADDR, TX_BASE);
        cfg_write(REG_TX_SIZE, N_TX * 4);
        cfg_write(REG_TX_CFG, EN_VAL);
        wait_events(1, base + 1, "transmit end of transfer");
        idle_cycles(4);
        check_cond(evt_cnt[1] == base + 1, $sformatf("%0d transmit events", evt_cnt[1] - base));
        check_tx_words(TX_BASE / 4, N_TX, N_TX, N_TX);
        check_reg(REG_TX_SIZE, '1, '0, "TX_SIZE after transfer");
        check_reg(REG_TX_CFG, EN_VAL, '0, "TX_CFG EN after transfer");
        end_test("transmit transfer");
    endtask

    task automatic run_rx_test();
        int    base;
        word_t w;
        base   = evt_cnt[0];
        wr_cnt = 0;
        rx_words.delete();
        cfg_write(REG_RX_SADDR, RX_BASE);
        cfg_write(REG_RX_SIZE, N_RX * 4);
        cfg_write(REG_RX_CFG, EN_VAL);
        for (int i = 0; i < N_RX; i++)
        begin
            w = $random(data_seed);
            rx_words.push_back(w);
            send_rx_word(w);
        end
        wait_events(0, base + 1, "receive end of transfer");
        idle_cycles(4);
        check_cond(evt_cnt[0] == base + 1, $sformatf("%0d receive events", evt_cnt[0] - base));
        check_cond(wr_cnt == N_RX, $sformatf("%0d L2 writes, expected %0d", wr_cnt, N_RX));
        foreach (rx_words[i])
            check_cond(l2_mem_i.mem[RX_BASE / 4 + i] == rx_words[i],
                       $sformatf("L2 word %0d is 0x%08h, expected 0x%08h", i,
                                 l2_mem_i.mem[RX_BASE / 4 + i], rx_words[i]));
        check_reg(REG_RX_CFG, EN_VAL, '0, "RX_CFG EN after transfer");
        end_test("receive transfer");
    endtask

    task automatic run_cont_test();
        int base;
        base = evt_cnt[1];
        tx_q.delete();
        cfg_write(REG_TX_SADDR, CONT_BASE);
        cfg_write(REG_TX_SIZE, N_CONT * 4);
        cfg_write(REG_TX_CFG, EN_VAL | CONT_VAL);
        wait_events(1, base + 2, "second continuous pass");
        check_reg(REG_TX_CFG, EN_VAL | CONT_VAL, EN_VAL | CONT_VAL, "TX_CFG in continuous mode");
        cfg_write(REG_TX_CFG, CLR_VAL);
        check_reg(REG_TX_CFG, EN_VAL, '0, "TX_CFG EN after clear");
        quiet_chk = 1'b1;
        idle_cycles(30);
        quiet_chk = 1'b0;
        check_tx_words(CONT_BASE / 4, N_CONT, 2 * N_CONT, 3 * N_CONT);
        end_test("continuous and clear");
    endtask

    initial
    begin
        reset         = 1'b1;
        cfg_valid     = 1'b0;
        cfg_rwn       = 1'b1;
        cfg_addr      = '0;
        cfg_wdata     = '0;
        rx_valid      = 1'b0;
        rx_data       = '0;
        quiet_chk     = 1'b0;
        err_cnt       = 0;
        test_err_base = 0;
        tests_run     = 0;
        tests_failed  = 0;
        evt_cnt[0]    = 0;
        evt_cnt[1]    = 0;
        wr_cnt        = 0;
        for (int i = 0; i < MEM_WORDS; i++)
            l2_mem_i.mem[i] = fill_word(i);
        repeat (8) @(posedge sys_clk);
        #1;
        reset = 1'b0;

        run_reset_test();
        run_regs_test();
        run_tx_test();
        run_rx_test();
        run_cont_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/udma_lite_pkg.sv
verilog/udma_ch_if.sv
verilog/udma_tx_ch.sv
verilog/udma_rx_ch.sv
verilog/udma_regs.sv
verilog/udma_lite.sv
sim/tb_l2_mem.sv
sim/tb_udma_lite.sv
